/* logic/tlk_pkg.sv */
`default_nettype none

package tlk_pkg;

    typedef logic [15:0] tlk_word_t;   // parallel serdes word
    typedef logic [4:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [31:0] cnt_t;

    typedef enum logic [2:0] {
        MODE_IDLE    = 3'd0,
        MODE_COUNT   = 3'd1,
        MODE_PRBS    = 3'd2,
        MODE_FIXED   = 3'd3,
        MODE_DEVPRBS = 3'd4
    } tlk_mode_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SYNC,
        TX_DATA
    } tx_state_t;

    typedef enum logic {
        RX_HUNT,
        RX_LOCKED
    } rx_state_t;

    localparam apb_addr_t REG_CTRL    = 5'h00;
    localparam apb_addr_t REG_PATTERN = 5'h04;
    localparam apb_addr_t REG_STATUS  = 5'h08;
    localparam apb_addr_t REG_WORDS   = 5'h0C;
    localparam apb_addr_t REG_ERRS    = 5'h10;

    localparam tlk_word_t K_COMMA   = 16'hBCBC;  // K28.5 in both bytes
    localparam tlk_word_t PRBS_SEED = 16'hACE1;

    // modes that put real data on the bus
    function automatic logic mode_has_data(tlk_mode_t mode);
        return (mode == MODE_COUNT) || (mode == MODE_PRBS) || (mode == MODE_FIXED);
    endfunction

    // first data word after the sync comma
    function automatic tlk_word_t seed_word(tlk_mode_t mode, tlk_word_t pattern);
        case (mode)
            MODE_COUNT: return 16'h0000;
            MODE_PRBS:  return PRBS_SEED;
            MODE_FIXED: return pattern;
            default:    return K_COMMA;
        endcase
    endfunction

    function automatic tlk_word_t next_word(tlk_mode_t mode, tlk_word_t cur,
                                            tlk_word_t pattern);
        case (mode)
            MODE_COUNT: return cur + 16'd1;
            // taps 16 15 13 4
            MODE_PRBS:  return {cur[14:0], cur[15] ^ cur[14] ^ cur[12] ^ cur[3]};
            MODE_FIXED: return pattern;
            default:    return K_COMMA;
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/tlk_ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface tlk_ctrl_if import tlk_pkg::*; ();

    logic      start;     // one-cycle pulses from regs
    logic      stop;
    logic      clr;
    tlk_mode_t mode;
    tlk_word_t pattern;

    logic      running;   // from generator
    logic      stop_ack;

    logic      locked;    // from checker
    cnt_t      word_cnt;
    cnt_t      err_cnt;

    modport regs (
        output start, stop, clr, mode, pattern,
        input  running, stop_ack, locked, word_cnt, err_cnt
    );

    modport tx (
        input  start, stop, mode, pattern,
        output running, stop_ack
    );

    modport rx (
        input  clr, mode, pattern,
        output locked, word_cnt, err_cnt
    );

endinterface

`default_nettype wire

/* logic/tlk_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module tlk_apb_regs import tlk_pkg::*; #(
    parameter int PWRUP_CYCLES = 200
) (
    input  wire logic      i_clk,
    input  wire logic      i_rstn,
    input  wire logic      i_psel,
    input  wire logic      i_penable,
    input  wire logic      i_pwrite,
    input  wire apb_addr_t i_paddr,
    input  wire apb_data_t i_pwdata,
    output apb_data_t      o_prdata,
    output logic           o_pready,
    output logic           o_pslverr,
    output logic           o_loopen,
    output logic           o_enable,
    output logic           o_lckrefn,
    tlk_ctrl_if.regs       ctrl
);

    localparam int PWR_W = $clog2(PWRUP_CYCLES + 1);
    localparam logic [PWR_W-1:0] PWR_LAST = PWR_W'(PWRUP_CYCLES);

    logic [PWR_W-1:0] pwr_cnt;
    logic             phy_ready;
    logic             access;
    logic             wr_en;
    logic             wr_ctrl;
    logic             addr_ok;
    tlk_mode_t        mode_q;
    tlk_word_t        pattern_q;
    logic             loopen_q;
    logic             ack_sticky;
    logic             start_q;
    logic             stop_q;
    logic             clr_q;

    // power-up hold of the transceiver, saturates at PWR_LAST
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            pwr_cnt <= '0;
        end else if (!phy_ready) begin
            pwr_cnt <= pwr_cnt + 1'b1;
        end
    end

    assign phy_ready = (pwr_cnt == PWR_LAST);
    assign o_enable  = phy_ready;
    assign o_lckrefn = phy_ready;

    assign access  = i_psel && i_penable;  // zero-wait access phase
    assign wr_en   = access && i_pwrite;
    assign wr_ctrl = wr_en && (i_paddr == REG_CTRL);

    always_comb begin
        case (i_paddr)
            REG_CTRL, REG_PATTERN, REG_STATUS, REG_WORDS, REG_ERRS: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    assign o_pready  = 1'b1;
    assign o_pslverr = access && (!addr_ok || (i_pwrite && i_paddr == REG_STATUS));

    always_comb begin
        case (i_paddr)
            REG_CTRL:    o_prdata = {25'd0, mode_q, 1'b0, loopen_q, 2'b00};
            REG_PATTERN: o_prdata = {16'd0, pattern_q};
            REG_STATUS:  o_prdata = {28'd0, phy_ready, ctrl.locked, ack_sticky, ctrl.running};
            REG_WORDS:   o_prdata = ctrl.word_cnt;
            REG_ERRS:    o_prdata = ctrl.err_cnt;
            default:     o_prdata = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            mode_q     <= MODE_IDLE;
            pattern_q  <= '0;
            loopen_q   <= 1'b0;
            start_q    <= 1'b0;
            stop_q     <= 1'b0;
            clr_q      <= 1'b0;
            ack_sticky <= 1'b0;
        end else begin
            start_q <= wr_ctrl && i_pwdata[0] && phy_ready;  // no start before phy up
            stop_q  <= wr_ctrl && i_pwdata[1];
            clr_q   <= wr_en && (i_paddr == REG_ERRS);
            if (wr_ctrl) begin
                loopen_q <= i_pwdata[2];
                if (!ctrl.running) begin
                    mode_q <= tlk_mode_t'(i_pwdata[6:4]);
                end
            end
            if (wr_en && (i_paddr == REG_PATTERN)) begin
                pattern_q <= i_pwdata[15:0];
            end
            if (start_q) begin
                ack_sticky <= 1'b0;
            end else if (ctrl.stop_ack) begin
                ack_sticky <= 1'b1;
            end
        end
    end

    assign ctrl.start   = start_q;
    assign ctrl.stop    = stop_q;
    assign ctrl.clr     = clr_q;
    assign ctrl.mode    = mode_q;
    assign ctrl.pattern = pattern_q;
    assign o_loopen     = loopen_q;

endmodule

`default_nettype wire

/* logic/tlk_tx_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tlk_tx_gen import tlk_pkg::*; (
    input  wire logic i_clk,
    input  wire logic i_rstn,
    tlk_ctrl_if.tx    ctrl,
    output tlk_word_t o_txd,
    output logic      o_tkmsb,
    output logic      o_tklsb,
    output logic      o_prbsen
);

    tx_state_t state_q;
    tlk_mode_t mode_q;      // mode latched at start
    tlk_word_t txd_q;
    logic      k_q;         // both K flags move together
    logic      stop_ack_q;
    logic      running;

    assign running = (state_q != TX_IDLE);

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            state_q    <= TX_IDLE;
            mode_q     <= MODE_IDLE;
            txd_q      <= K_COMMA;
            k_q        <= 1'b1;
            stop_ack_q <= 1'b0;
        end else begin
            stop_ack_q <= 1'b0;
            case (state_q)
                TX_IDLE: begin
                    txd_q <= K_COMMA;
                    k_q   <= 1'b1;
                    if (ctrl.stop) begin
                        stop_ack_q <= 1'b1;      // ack even when already idle
                    end else if (ctrl.start) begin
                        state_q <= TX_SYNC;
                        mode_q  <= ctrl.mode;
                    end
                end
                TX_SYNC: begin
                    if (ctrl.stop) begin
                        state_q    <= TX_IDLE;
                        stop_ack_q <= 1'b1;
                    end else begin
                        state_q <= TX_DATA;
                        txd_q   <= seed_word(mode_q, ctrl.pattern);
                        k_q     <= !mode_has_data(mode_q);
                    end
                end
                TX_DATA: begin
                    if (ctrl.stop) begin
                        state_q    <= TX_IDLE;
                        txd_q      <= K_COMMA;
                        k_q        <= 1'b1;
                        stop_ack_q <= 1'b1;
                    end else begin
                        // one word per cycle, no back-pressure
                        txd_q <= next_word(mode_q, txd_q, ctrl.pattern);
                        k_q   <= !mode_has_data(mode_q);
                    end
                end
                default: begin
                    state_q <= TX_IDLE;
                    txd_q   <= K_COMMA;
                    k_q     <= 1'b1;
                end
            endcase
        end
    end

    assign o_txd    = txd_q;
    assign o_tkmsb  = k_q;
    assign o_tklsb  = k_q;
    assign o_prbsen = running && (mode_q == MODE_DEVPRBS);  // device-internal PRBS

    assign ctrl.running  = running;
    assign ctrl.stop_ack = stop_ack_q;

endmodule

`default_nettype wire

/* logic/tlk_rx_check.sv */
`timescale 1ns/1ns
`default_nettype none

module tlk_rx_check import tlk_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rstn,
    input  wire tlk_word_t i_rxd,
    input  wire logic      i_rkmsb,
    input  wire logic      i_rklsb,
    tlk_ctrl_if.rx         ctrl
);

    tlk_word_t rxd_q;
    logic      rkm_q;
    logic      rkl_q;
    rx_state_t state_q;
    tlk_word_t exp_q;       // predicted word
    cnt_t      word_cnt_q;
    cnt_t      err_cnt_q;
    logic      is_comma;
    logic      is_data;
    logic      dev_mode;

    // one input stage on the receive bus
    always_ff @(posedge i_clk) begin
        rxd_q <= i_rxd;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            rkm_q <= 1'b0;
            rkl_q <= 1'b0;
        end else begin
            rkm_q <= i_rkmsb;
            rkl_q <= i_rklsb;
        end
    end

    assign is_comma = (rxd_q == K_COMMA) && rkm_q && rkl_q;
    assign is_data  = !rkm_q && !rkl_q;
    assign dev_mode = (ctrl.mode == MODE_DEVPRBS);

    // prediction runs every cycle, a comma reloads the seed
    always_ff @(posedge i_clk) begin
        if (is_comma) begin
            exp_q <= seed_word(ctrl.mode, ctrl.pattern);
        end else begin
            exp_q <= next_word(ctrl.mode, exp_q, ctrl.pattern);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstn || ctrl.clr) begin
            state_q    <= RX_HUNT;
            word_cnt_q <= '0;
            err_cnt_q  <= '0;
        end else begin
            case (state_q)
                RX_HUNT: begin
                    if (is_comma && !dev_mode) begin
                        state_q <= RX_LOCKED;
                    end
                end
                RX_LOCKED: begin
                    if (dev_mode) begin
                        state_q <= RX_HUNT;       // device PRBS is not checked here
                    end else if (is_data) begin
                        if (word_cnt_q != '1) begin
                            word_cnt_q <= word_cnt_q + 1'b1;
                        end
                        if ((rxd_q != exp_q) && (err_cnt_q != '1)) begin
                            err_cnt_q <= err_cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= RX_HUNT;
            endcase
        end
    end

    assign ctrl.locked   = (state_q == RX_LOCKED);
    assign ctrl.word_cnt = word_cnt_q;
    assign ctrl.err_cnt  = err_cnt_q;

endmodule

`default_nettype wire

/* logic/tlk2711_test_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tlk2711_test_top import tlk_pkg::*; #(
    parameter int PWRUP_CYCLES = 200
) (
    input  wire logic      sys_clk_50,
    input  wire logic      sys_rstn,
    // apb slave
    input  wire logic      i_psel,
    input  wire logic      i_penable,
    input  wire logic      i_pwrite,
    input  wire apb_addr_t i_paddr,
    input  wire apb_data_t i_pwdata,
    output apb_data_t      o_prdata,
    output logic           o_pready,
    output logic           o_pslverr,
    // tlk2711 transmit side
    output tlk_word_t      o_tlk_txd,
    output logic           o_tlk_tkmsb,
    output logic           o_tlk_tklsb,
    output logic           o_tlk_prbsen,
    output logic           o_tlk_loopen,
    output logic           o_tlk_enable,
    output logic           o_tlk_lckrefn,
    // tlk2711 receive side, taken as synchronous to sys_clk_50
    input  wire tlk_word_t i_tlk_rxd,
    input  wire logic      i_tlk_rkmsb,
    input  wire logic      i_tlk_rklsb
);

    tlk_ctrl_if i_ctrl_if ();

    tlk_apb_regs #(
        .PWRUP_CYCLES (PWRUP_CYCLES)
    ) i_apb_regs (
        .i_clk     (sys_clk_50),
        .i_rstn    (sys_rstn),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_loopen  (o_tlk_loopen),
        .o_enable  (o_tlk_enable),
        .o_lckrefn (o_tlk_lckrefn),
        .ctrl      (i_ctrl_if.regs)
    );

    tlk_tx_gen i_tx_gen (
        .i_clk    (sys_clk_50),
        .i_rstn   (sys_rstn),
        .ctrl     (i_ctrl_if.tx),
        .o_txd    (o_tlk_txd),
        .o_tkmsb  (o_tlk_tkmsb),
        .o_tklsb  (o_tlk_tklsb),
        .o_prbsen (o_tlk_prbsen)
    );

    tlk_rx_check i_rx_check (
        .i_clk   (sys_clk_50),
        .i_rstn  (sys_rstn),
        .i_rxd   (i_tlk_rxd),
        .i_rkmsb (i_tlk_rkmsb),
        .i_rklsb (i_tlk_rklsb),
        .ctrl    (i_ctrl_if.rx)
    );

endmodule

`default_nettype wire

/* verif/tlk2711_test_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module tlk2711_test_assert import tlk_pkg::*; (
    input wire logic      i_clk,
    input wire logic      i_rstn,
    input wire logic      i_psel,
    input wire logic      i_penable,
    input wire logic      i_pready,
    input wire logic      i_pslverr,
    input wire tlk_word_t i_txd,
    input wire logic      i_tkmsb,
    input wire logic      i_tklsb,
    input wire logic      i_enable,
    input wire logic      i_running
);

    // idle generator only ever sends K28.5 commas
    a_idle_comma: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !i_running |-> (i_txd == K_COMMA) && i_tkmsb && i_tklsb)
        else $error("idle word is not a K comma");

    a_pready: assert property (@(posedge i_clk) disable iff (!i_rstn)
        (i_psel && i_penable) |-> i_pready)
        else $error("pready low in access phase");

    a_pslverr: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !(i_psel && i_penable) |-> !i_pslverr)
        else $error("pslverr outside access phase");

    a_enable_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !$fell(i_enable))
        else $error("enable fell after power-up");

endmodule

bind tlk2711_test_top tlk2711_test_assert i_tlk2711_test_assert (
    .i_clk     (sys_clk_50),
    .i_rstn    (sys_rstn),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pready  (o_pready),
    .i_pslverr (o_pslverr),
    .i_txd     (o_tlk_txd),
    .i_tkmsb   (o_tlk_tkmsb),
    .i_tklsb   (o_tlk_tklsb),
    .i_enable  (o_tlk_enable),
    .i_running (i_ctrl_if.running)
);

`default_nettype wire

/* verif/tb_tlk2711_test.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_tlk2711_test import tlk_pkg::*; ();

    localparam int MAX_CYCLES = 4000;  // bursts total well under 1000 cycles

    logic      sys_clk_50;
    logic      sys_rstn;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    tlk_word_t txd;
    logic      tkmsb;
    logic      tklsb;
    logic      prbsen;
    logic      loopen;
    logic      enable;
    logic      lckrefn;
    tlk_word_t rxd;
    logic      rkmsb;
    logic      rklsb;

    integer    seed = 32'hfd7e;
    int        errs = 0;
    int        cycles = 0;
    logic      loop_on;
    logic      inj_en;
    logic      mdl_locked;
    cnt_t      mdl_words;
    cnt_t      mdl_errs;
    tlk_mode_t cur_mode;
    tlk_word_t pat;

    tlk2711_test_top #(
        .PWRUP_CYCLES (20)
    ) i_tlk2711_test_top (
        .sys_clk_50    (sys_clk_50),
        .sys_rstn      (sys_rstn),
        .i_psel        (psel),
        .i_penable     (penable),
        .i_pwrite      (pwrite),
        .i_paddr       (paddr),
        .i_pwdata      (pwdata),
        .o_prdata      (prdata),
        .o_pready      (pready),
        .o_pslverr     (pslverr),
        .o_tlk_txd     (txd),
        .o_tlk_tkmsb   (tkmsb),
        .o_tlk_tklsb   (tklsb),
        .o_tlk_prbsen  (prbsen),
        .o_tlk_loopen  (loopen),
        .o_tlk_enable  (enable),
        .o_tlk_lckrefn (lckrefn),
        .i_tlk_rxd     (rxd),
        .i_tlk_rkmsb   (rkmsb),
        .i_tlk_rklsb   (rklsb)
    );

    initial begin
        sys_clk_50 = 1'b0;
        forever #2 sys_clk_50 = ~sys_clk_50;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge sys_clk_50);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    // reference sequence, same rules as the generator
    function automatic tlk_word_t first_word(tlk_mode_t m, tlk_word_t p);
        case (m)
            MODE_COUNT: return 16'h0000;
            MODE_PRBS:  return 16'hACE1;
            MODE_FIXED: return p;
            default:    return 16'hBCBC;
        endcase
    endfunction

    function automatic tlk_word_t advance_word(tlk_mode_t m, tlk_word_t cur, tlk_word_t p);
        case (m)
            MODE_COUNT: return cur + 16'd1;
            MODE_PRBS:  return {cur[14:0], ^(cur & 16'hD008)};  // bits 15 14 12 3
            MODE_FIXED: return p;
            default:    return 16'hBCBC;
        endcase
    endfunction

    task automatic check_word(input tlk_word_t got, input tlk_word_t exp, input string what);
        if (got !== exp) begin
            errs++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cnt(input cnt_t got, input cnt_t exp, input string what);
        if (got !== exp) begin
            errs++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_apb(input apb_data_t got, input apb_data_t exp, input string what);
        if (got !== exp) begin
            errs++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errs++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic step();
        @(posedge sys_clk_50);
        #1;
    endtask

    task automatic apb_write(input apb_addr_t a, input apb_data_t d, output logic err);
        step();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = a;
        pwdata  = d;
        step();
        penable = 1'b1;
        #1;
        err = pslverr;
        check_bit(pready, 1'b1, "pready in write access");
        step();  // write lands on the edge just passed
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t a, output apb_data_t d, output logic err);
        step();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = a;
        step();
        penable = 1'b1;
        #1;
        d   = prdata;
        err = pslverr;
        check_bit(pready, 1'b1, "pready in read access");
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // loopback with one register stage and random single-bit errors on data words
    initial begin
        integer    r;
        tlk_word_t w;
        tlk_word_t m;
        logic      k;
        forever begin
            step();
            w = txd;
            k = tkmsb;
            m = '0;
            if (!loop_on) begin
                rxd   = '0;
                rkmsb = 1'b0;
                rklsb = 1'b0;
            end else begin
                if (!k && inj_en) begin
                    r = $random(seed);
                    if (r[3:0] == 4'd0) begin
                        r = $random(seed);
                        m = 16'd1 << r[3:0];
                    end
                end
                rxd   = w ^ m;
                rkmsb = tkmsb;
                rklsb = tklsb;
                if (k && (w == 16'hBCBC)) begin
                    mdl_locked = (cur_mode != MODE_DEVPRBS);
                end else if (!k && mdl_locked) begin
                    mdl_words++;
                    if (m != '0) mdl_errs++;
                end
            end
        end
    end

    task automatic run_burst(input tlk_mode_t mode, input int nwords);
        tlk_word_t exp;
        apb_data_t rd;
        logic      err;
        logic      lk;
        cur_mode = mode;
        inj_en   = 1'b1;
        apb_write(REG_CTRL, {25'd0, mode, 4'h1}, err);
        step();
        check_word(txd, 16'hBCBC, "sync word");
        check_bit(tkmsb & tklsb, 1'b1, "sync k flags");
        exp = first_word(mode, pat);
        for (int i = 0; i < nwords; i++) begin
            step();
            if (mode == MODE_DEVPRBS) begin
                check_bit(prbsen, 1'b1, "prbsen while running");
            end else begin
                check_word(txd, exp, "tx data");
                check_bit(tkmsb | tklsb, 1'b0, "data k flags");
                exp = advance_word(mode, exp, pat);
            end
        end
        apb_write(REG_CTRL, {25'd0, mode, 4'h2}, err);
        repeat (2) step();
        check_word(txd, 16'hBCBC, "comma after stop");
        check_bit(tkmsb & tklsb, 1'b1, "k flags after stop");
        check_bit(prbsen, 1'b0, "prbsen after stop");
        inj_en = 1'b0;
        repeat (4) step();  // let the loopback and checker drain
        lk = (mode != MODE_DEVPRBS);
        apb_read(REG_STATUS, rd, err);
        check_apb(rd, {28'd0, 1'b1, lk, 1'b1, 1'b0}, "status after stop");
        apb_read(REG_WORDS, rd, err);
        check_cnt(rd, mdl_words, "word count");
        apb_read(REG_ERRS, rd, err);
        check_cnt(rd, mdl_errs, "error count");
    endtask

    task automatic clear_counters();
        apb_data_t rd;
        logic      err;
        loop_on = 1'b0;  // no commas, so the checker stays in hunt after clr
        repeat (3) step();
        apb_write(REG_ERRS, '0, err);
        mdl_words  = '0;
        mdl_errs   = '0;
        mdl_locked = 1'b0;
        apb_read(REG_STATUS, rd, err);
        check_bit(rd[2], 1'b0, "locked after clear");
        apb_read(REG_WORDS, rd, err);
        check_cnt(rd, '0, "words after clear");
        apb_read(REG_ERRS, rd, err);
        check_cnt(rd, '0, "errs after clear");
        loop_on = 1'b1;
        repeat (4) step();
    endtask

    initial begin
        apb_data_t rd;
        logic      err;
        integer    r;
        sys_rstn   = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        rxd        = '0;
        rkmsb      = 1'b0;
        rklsb      = 1'b0;
        loop_on    = 1'b1;
        inj_en     = 1'b0;
        mdl_locked = 1'b0;
        mdl_words  = '0;
        mdl_errs   = '0;
        cur_mode   = MODE_IDLE;
        pat        = '0;

        repeat (3) step();
        check_word(txd, 16'hBCBC, "reset txd");
        check_bit(tkmsb & tklsb, 1'b1, "reset k flags");
        check_bit(prbsen, 1'b0, "reset prbsen");
        check_bit(loopen, 1'b0, "reset loopen");
        check_bit(enable, 1'b0, "reset enable");
        check_bit(lckrefn, 1'b0, "reset lckrefn");
        check_bit(pslverr, 1'b0, "reset pslverr");
        sys_rstn = 1'b1;
        for (int k = 1; k <= 20; k++) begin
            step();
            check_bit(enable, (k == 20), "power-up enable");
            check_bit(lckrefn, (k == 20), "power-up lckrefn");
        end

        // register file
        for (int i = 0; i < 4; i++) begin
            r   = $random(seed);
            pat = r[15:0];
            apb_write(REG_PATTERN, {16'd0, pat}, err);
            apb_read(REG_PATTERN, rd, err);
            check_apb(rd, {16'd0, pat}, "pattern readback");
        end
        apb_write(REG_CTRL, 32'h0000_0036, err);  // fixed mode, loopen, stop pulse
        apb_read(REG_CTRL, rd, err);
        check_apb(rd, 32'h0000_0034, "ctrl readback");
        check_bit(loopen, 1'b1, "loopen set");
        apb_write(REG_CTRL, 32'h0000_0030, err);
        check_bit(loopen, 1'b0, "loopen clear");
        apb_read(5'h14, rd, err);
        check_bit(err, 1'b1, "unmapped read pslverr");
        apb_write(5'h1C, 32'h1, err);
        check_bit(err, 1'b1, "unmapped write pslverr");
        apb_write(REG_STATUS, 32'hF, err);
        check_bit(err, 1'b1, "status write pslverr");
        apb_read(REG_STATUS, rd, err);
        check_bit(err, 1'b0, "status read pslverr");

        run_burst(MODE_COUNT, 40);
        r   = $random(seed);
        pat = r[15:0];
        apb_write(REG_PATTERN, {16'd0, pat}, err);
        run_burst(MODE_PRBS, 64);
        run_burst(MODE_FIXED, 32);
        clear_counters();
        run_burst(MODE_DEVPRBS, 16);

        $display("checks done, errors: %0d", errs);
        if (errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/tlk_pkg.sv
logic/tlk_ctrl_if.sv
logic/tlk_apb_regs.sv
logic/tlk_tx_gen.sv
logic/tlk_rx_check.sv
logic/tlk2711_test_top.sv
verif/tlk2711_test_assert.sv
verif/tb_tlk2711_test.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tlk2711_test
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

# build, run and grep the output for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
